//--- common/rename_pkg.sv
package rename_pkg;

    localparam int ARCH_REG_NUM = 32;
    localparam int PHY_REG_NUM = 64;
    localparam int FREE_DEPTH = PHY_REG_NUM - ARCH_REG_NUM;

    localparam int ARCH_REG_W = $clog2(ARCH_REG_NUM);
    localparam int PHY_REG_W = $clog2(PHY_REG_NUM);

    typedef logic [ARCH_REG_W-1:0] arch_reg_t;
    typedef logic [PHY_REG_W-1:0] phy_reg_t;

    // One decoded instruction as seen by rename
    typedef struct packed {
        logic      valid;
        logic      uses_rs1;
        logic      uses_rs2;
        logic      wr_reg;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
    } rename_req_t;

    typedef struct packed {
        logic     valid;
        phy_reg_t phy_src1;
        phy_reg_t phy_src2;
        phy_reg_t phy_dst;
        // Freed by the ROB when this instruction commits
        phy_reg_t phy_ori_dst;
    } rename_resp_t;

    typedef struct packed {
        logic     valid;
        phy_reg_t tag;
    } release_t;

endpackage

//--- rename/free_tag_list.sv
`timescale 1ns/1ps

module free_tag_list (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [1:0]                     pop_count,
    input  rename_pkg::release_t           rel_1,
    input  rename_pkg::release_t           rel_2,
    output rename_pkg::phy_reg_t           head_1,
    output rename_pkg::phy_reg_t           head_2,
    output logic [rename_pkg::PHY_REG_W:0] free_count
);

    localparam int PTR_W = $clog2(rename_pkg::FREE_DEPTH);
    localparam int COUNT_W = rename_pkg::PHY_REG_W + 1;

    rename_pkg::phy_reg_t tags [rename_pkg::FREE_DEPTH];

    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   rd_ptr_1;
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   wr_ptr_2;
    logic [1:0]         push_count;
    logic [COUNT_W-1:0] count;
    logic [COUNT_W-1:0] count_next;

    assign rd_ptr_1 = rd_ptr + PTR_W'(1);

    // Two oldest entries, valid as far as count allows
    assign head_1 = tags[rd_ptr];
    assign head_2 = tags[rd_ptr_1];

    assign push_count = {1'b0, rel_1.valid} + {1'b0, rel_2.valid};

    // rel_2 goes behind rel_1 when both are present
    assign wr_ptr_2 = wr_ptr + PTR_W'(rel_1.valid);

    assign count_next = count + COUNT_W'(push_count) - COUNT_W'(pop_count);
    assign free_count = count;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= COUNT_W'(rename_pkg::FREE_DEPTH);
        end else begin
            rd_ptr <= rd_ptr + PTR_W'(pop_count);
            wr_ptr <= wr_ptr + PTR_W'(push_count);
            count <= count_next;
        end
    end

    // Starts full with every tag above the architectural range
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::FREE_DEPTH; i++) begin
                tags[i] <= rename_pkg::phy_reg_t'(rename_pkg::ARCH_REG_NUM + i);
            end
        end else begin
            if (rel_1.valid) begin
                tags[wr_ptr] <= rel_1.tag;
            end
            if (rel_2.valid) begin
                tags[wr_ptr_2] <= rel_2.tag;
            end
        end
    end

    // Accept decision upstream must never ask for more than is here
    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        COUNT_W'(pop_count) <= count);

    // Commit only returns tags that were handed out
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        count_next <= COUNT_W'(rename_pkg::FREE_DEPTH));

endmodule

//--- rename/map_table.sv
`timescale 1ns/1ps

module map_table (
    input  logic                  clk,
    input  logic                  reset,
    input  rename_pkg::arch_reg_t rd_addr_1,
    input  rename_pkg::arch_reg_t rd_addr_2,
    input  rename_pkg::arch_reg_t rd_addr_3,
    input  rename_pkg::arch_reg_t rd_addr_4,
    input  rename_pkg::arch_reg_t rd_addr_5,
    input  rename_pkg::arch_reg_t rd_addr_6,
    output rename_pkg::phy_reg_t  rd_data_1,
    output rename_pkg::phy_reg_t  rd_data_2,
    output rename_pkg::phy_reg_t  rd_data_3,
    output rename_pkg::phy_reg_t  rd_data_4,
    output rename_pkg::phy_reg_t  rd_data_5,
    output rename_pkg::phy_reg_t  rd_data_6,
    input  logic                  we_1,
    input  logic                  we_2,
    input  rename_pkg::arch_reg_t wr_addr_1,
    input  rename_pkg::arch_reg_t wr_addr_2,
    input  rename_pkg::phy_reg_t  wr_data_1,
    input  rename_pkg::phy_reg_t  wr_data_2
);

    rename_pkg::phy_reg_t map [rename_pkg::ARCH_REG_NUM];

    assign rd_data_1 = map[rd_addr_1];
    assign rd_data_2 = map[rd_addr_2];
    assign rd_data_3 = map[rd_addr_3];
    assign rd_data_4 = map[rd_addr_4];
    assign rd_data_5 = map[rd_addr_5];
    assign rd_data_6 = map[rd_addr_6];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::ARCH_REG_NUM; i++) begin
                map[i] <= rename_pkg::phy_reg_t'(i);
            end
        end else begin
            if (we_1) begin
                map[wr_addr_1] <= wr_data_1;
            end
            // Younger slot lands last on a shared rd
            if (we_2) begin
                map[wr_addr_2] <= wr_data_2;
            end
        end
    end

    // New tags come from the free list, so never the current mapping
    a_wr_tag_1_fresh: assert property (@(posedge clk) disable iff (reset)
        we_1 |-> !$isunknown(wr_data_1) && (wr_data_1 != map[wr_addr_1]));

    a_wr_tag_2_fresh: assert property (@(posedge clk) disable iff (reset)
        we_2 |-> !$isunknown(wr_data_2) && (wr_data_2 != map[wr_addr_2]));

endmodule

//--- rename/group_bypass.sv
`timescale 1ns/1ps

module group_bypass (
    input  rename_pkg::rename_req_t  req_1,
    input  rename_pkg::rename_req_t  req_2,
    input  rename_pkg::phy_reg_t     map_src1_1,
    input  rename_pkg::phy_reg_t     map_src2_1,
    input  rename_pkg::phy_reg_t     map_src1_2,
    input  rename_pkg::phy_reg_t     map_src2_2,
    input  rename_pkg::phy_reg_t     map_ori_1,
    input  rename_pkg::phy_reg_t     map_ori_2,
    input  rename_pkg::phy_reg_t     new_dst_1,
    input  rename_pkg::phy_reg_t     new_dst_2,
    output rename_pkg::rename_resp_t resp_1,
    output rename_pkg::rename_resp_t resp_2
);

    logic writes_1;
    logic writes_2;
    logic raw_src1;
    logic raw_src2;
    logic waw;
    rename_pkg::phy_reg_t dst_1;
    rename_pkg::phy_reg_t dst_2;

    assign writes_1 = req_1.valid && req_1.wr_reg;
    assign writes_2 = req_2.valid && req_2.wr_reg;

    // Oldest free tag goes to the first writer in slot order
    assign dst_1 = writes_1 ? new_dst_1 : '0;
    assign dst_2 = !writes_2 ? '0 : (writes_1 ? new_dst_2 : new_dst_1);

    // Hazards only exist if slot 1 really writes
    assign raw_src1 = writes_1 && (req_2.rs1 == req_1.rd);
    assign raw_src2 = writes_1 && (req_2.rs2 == req_1.rd);
    assign waw = writes_1 && (req_2.rd == req_1.rd);

    always_comb begin
        resp_1.valid = req_1.valid;
        resp_1.phy_src1 = req_1.uses_rs1 ? map_src1_1 : '0;
        resp_1.phy_src2 = req_1.uses_rs2 ? map_src2_1 : '0;
        resp_1.phy_dst = dst_1;
        resp_1.phy_ori_dst = writes_1 ? map_ori_1 : '0;
    end

    always_comb begin
        resp_2.valid = req_2.valid;
        resp_2.phy_src1 = '0;
        resp_2.phy_src2 = '0;
        if (req_2.uses_rs1) begin
            resp_2.phy_src1 = raw_src1 ? dst_1 : map_src1_2;
        end
        if (req_2.uses_rs2) begin
            resp_2.phy_src2 = raw_src2 ? dst_1 : map_src2_2;
        end
        resp_2.phy_dst = dst_2;
        // Map still holds the pre-group value, slot 1 overwrote it
        resp_2.phy_ori_dst = !writes_2 ? '0 : (waw ? dst_1 : map_ori_2);
    end

endmodule

//--- rename/rename_unit.sv
`timescale 1ns/1ps

module rename_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  rename_pkg::rename_req_t  req_1,
    input  rename_pkg::rename_req_t  req_2,
    input  rename_pkg::release_t     rel_1,
    input  rename_pkg::release_t     rel_2,
    output rename_pkg::rename_resp_t resp_1,
    output rename_pkg::rename_resp_t resp_2,
    output logic                     accepted
);

    logic group_valid;
    logic writes_1;
    logic writes_2;
    logic [1:0] need;
    logic accept;
    logic [1:0] pop_count;
    logic [rename_pkg::PHY_REG_W:0] free_count;
    logic we_1;
    logic we_2;

    rename_pkg::phy_reg_t head_1;
    rename_pkg::phy_reg_t head_2;
    rename_pkg::phy_reg_t map_src1_1;
    rename_pkg::phy_reg_t map_src2_1;
    rename_pkg::phy_reg_t map_src1_2;
    rename_pkg::phy_reg_t map_src2_2;
    rename_pkg::phy_reg_t map_ori_1;
    rename_pkg::phy_reg_t map_ori_2;

    rename_pkg::rename_resp_t next_1;
    rename_pkg::rename_resp_t next_2;
    rename_pkg::rename_resp_t gated_1;
    rename_pkg::rename_resp_t gated_2;

    assign group_valid = req_1.valid || req_2.valid;
    assign writes_1 = req_1.valid && req_1.wr_reg;
    assign writes_2 = req_2.valid && req_2.wr_reg;
    assign need = {1'b0, writes_1} + {1'b0, writes_2};

    // Releases in this cycle only show up in free_count next cycle
    assign accept = group_valid && (free_count >= (rename_pkg::PHY_REG_W + 1)'(need));

    assign pop_count = accept ? need : 2'd0;
    assign we_1 = accept && writes_1;
    assign we_2 = accept && writes_2;

    free_tag_list i_free_tag_list (
        .clk        (clk),
        .reset      (reset),
        .pop_count  (pop_count),
        .rel_1      (rel_1),
        .rel_2      (rel_2),
        .head_1     (head_1),
        .head_2     (head_2),
        .free_count (free_count)
    );

    map_table i_map_table (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_1 (req_1.rs1),
        .rd_addr_2 (req_1.rs2),
        .rd_addr_3 (req_2.rs1),
        .rd_addr_4 (req_2.rs2),
        .rd_addr_5 (req_1.rd),
        .rd_addr_6 (req_2.rd),
        .rd_data_1 (map_src1_1),
        .rd_data_2 (map_src2_1),
        .rd_data_3 (map_src1_2),
        .rd_data_4 (map_src2_2),
        .rd_data_5 (map_ori_1),
        .rd_data_6 (map_ori_2),
        .we_1      (we_1),
        .we_2      (we_2),
        .wr_addr_1 (req_1.rd),
        .wr_addr_2 (req_2.rd),
        .wr_data_1 (next_1.phy_dst),
        .wr_data_2 (next_2.phy_dst)
    );

    group_bypass i_group_bypass (
        .req_1      (req_1),
        .req_2      (req_2),
        .map_src1_1 (map_src1_1),
        .map_src2_1 (map_src2_1),
        .map_src1_2 (map_src1_2),
        .map_src2_2 (map_src2_2),
        .map_ori_1  (map_ori_1),
        .map_ori_2  (map_ori_2),
        .new_dst_1  (head_1),
        .new_dst_2  (head_2),
        .resp_1     (gated_1),
        .resp_2     (gated_2)
    );

    // A rejected group leaves no valid slot behind
    always_comb begin
        next_1 = gated_1;
        next_2 = gated_2;
        next_1.valid = accept && gated_1.valid;
        next_2.valid = accept && gated_2.valid;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_1.valid <= 1'b0;
            resp_2.valid <= 1'b0;
            accepted <= 1'b0;
        end else begin
            resp_1 <= next_1;
            resp_2 <= next_2;
            accepted <= accept;
        end
    end

endmodule

//--- tests/rename_model.svh
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

typedef struct packed {
    rename_pkg::rename_resp_t resp_1;
    rename_pkg::rename_resp_t resp_2;
    logic                     accepted;
} group_expect_t;

// Architectural state as the rename rules describe it
rename_pkg::phy_reg_t model_map [rename_pkg::ARCH_REG_NUM];
rename_pkg::phy_reg_t model_free [$];

function automatic void model_reset();
    model_free.delete();
    for (int i = 0; i < rename_pkg::ARCH_REG_NUM; i++) begin
        model_map[i] = rename_pkg::phy_reg_t'(i);
    end
    for (int i = rename_pkg::ARCH_REG_NUM; i < rename_pkg::PHY_REG_NUM; i++) begin
        model_free.push_back(rename_pkg::phy_reg_t'(i));
    end
endfunction

// Slots handled one after the other, so slot 2 sees slot 1's write
function automatic rename_pkg::rename_resp_t rename_slot(input rename_pkg::rename_req_t req);
    rename_pkg::rename_resp_t resp;
    resp = '0;
    if (req.valid) begin
        resp.valid = 1'b1;
        if (req.uses_rs1) begin
            resp.phy_src1 = model_map[req.rs1];
        end
        if (req.uses_rs2) begin
            resp.phy_src2 = model_map[req.rs2];
        end
        if (req.wr_reg) begin
            resp.phy_ori_dst = model_map[req.rd];
            resp.phy_dst = model_free.pop_front();
            model_map[req.rd] = resp.phy_dst;
        end
    end
    return resp;
endfunction

function automatic group_expect_t predict_group(input rename_pkg::rename_req_t r1,
                                                input rename_pkg::rename_req_t r2);
    group_expect_t e;
    int need;
    e = '0;
    need = int'(r1.valid && r1.wr_reg) + int'(r2.valid && r2.wr_reg);
    // Free count from the start of the cycle decides
    e.accepted = (r1.valid || r2.valid) && (need <= model_free.size());
    if (e.accepted) begin
        e.resp_1 = rename_slot(r1);
        e.resp_2 = rename_slot(r2);
    end
    return e;
endfunction

function automatic void apply_releases(input rename_pkg::release_t l1,
                                       input rename_pkg::release_t l2);
    if (l1.valid) begin
        model_free.push_back(l1.tag);
    end
    if (l2.valid) begin
        model_free.push_back(l2.tag);
    end
endfunction

`endif

//--- tests/rename_tb.sv
`timescale 1ns/1ps

module rename_tb;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_CYCLES = 300;
    localparam int TEST_CYCLES = RESET_CYCLES + 40 + RANDOM_CYCLES;

    logic clk;
    logic reset;
    rename_pkg::rename_req_t req_1;
    rename_pkg::rename_req_t req_2;
    rename_pkg::release_t rel_1;
    rename_pkg::release_t rel_2;
    rename_pkg::rename_resp_t resp_1;
    rename_pkg::rename_resp_t resp_2;
    logic accepted;

    `include "rename_model.svh"

    group_expect_t expect_q [$];
    rename_pkg::phy_reg_t release_pool [$];
    logic [31:0] lfsr_state = 32'h8a8a_3fe5;
    int check_count = 0;
    int reject_count = 0;

    rename_unit i_rename_unit (
        .clk      (clk),
        .reset    (reset),
        .req_1    (req_1),
        .req_2    (req_2),
        .rel_1    (rel_1),
        .rel_2    (rel_2),
        .resp_1   (resp_1),
        .resp_2   (resp_2),
        .accepted (accepted)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic random_bit();
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        return lfsr_state[0];
    endfunction

    function automatic logic [31:0] random_field(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], random_bit()};
        end
        return v;
    endfunction

    function automatic rename_pkg::rename_req_t make_req(input logic wr, input int rd,
                                                         input logic u1, input int rs1,
                                                         input logic u2, input int rs2);
        rename_pkg::rename_req_t r;
        r.valid = 1'b1;
        r.wr_reg = wr;
        r.uses_rs1 = u1;
        r.uses_rs2 = u2;
        r.rd = rename_pkg::arch_reg_t'(rd);
        r.rs1 = rename_pkg::arch_reg_t'(rs1);
        r.rs2 = rename_pkg::arch_reg_t'(rs2);
        return r;
    endfunction

    // Few registers so hazards inside a group are common
    function automatic rename_pkg::rename_req_t random_req();
        rename_pkg::rename_req_t r;
        r.valid = random_bit();
        r.uses_rs1 = random_bit();
        r.uses_rs2 = random_bit();
        r.wr_reg = random_bit();
        r.rs1 = rename_pkg::arch_reg_t'(random_field(3));
        r.rs2 = rename_pkg::arch_reg_t'(random_field(3));
        r.rd = rename_pkg::arch_reg_t'(random_field(3));
        return r;
    endfunction

    function automatic rename_pkg::release_t take_release();
        rename_pkg::release_t l;
        l = '0;
        if (release_pool.size() > 0) begin
            l.valid = 1'b1;
            l.tag = release_pool.pop_front();
        end
        return l;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic compare_resp(input string slot, input rename_pkg::rename_resp_t got,
                                input rename_pkg::rename_resp_t want);
        check_value({slot, ".valid"}, 32'(got.valid), 32'(want.valid));
        if (want.valid) begin
            check_value({slot, ".phy_src1"}, 32'(got.phy_src1), 32'(want.phy_src1));
            check_value({slot, ".phy_src2"}, 32'(got.phy_src2), 32'(want.phy_src2));
            check_value({slot, ".phy_dst"}, 32'(got.phy_dst), 32'(want.phy_dst));
            check_value({slot, ".phy_ori_dst"}, 32'(got.phy_ori_dst), 32'(want.phy_ori_dst));
        end
    endtask

    task automatic drive_cycle(input rename_pkg::rename_req_t r1, input rename_pkg::rename_req_t r2,
                               input rename_pkg::release_t l1, input rename_pkg::release_t l2);
        group_expect_t e;
        @(posedge clk);
        #2;
        req_1 = r1;
        req_2 = r2;
        rel_1 = l1;
        rel_2 = l2;
        e = predict_group(r1, r2);
        if ((r1.valid || r2.valid) && !e.accepted) begin
            reject_count++;
        end
        // Old destinations are what commit would free later
        if (e.resp_1.valid && r1.wr_reg) begin
            release_pool.push_back(e.resp_1.phy_ori_dst);
        end
        if (e.resp_2.valid && r2.wr_reg) begin
            release_pool.push_back(e.resp_2.phy_ori_dst);
        end
        apply_releases(l1, l2);
        expect_q.push_back(e);
    endtask

    // Response of a group is registered at the edge after it was driven
    initial begin
        group_expect_t e;
        forever begin
            @(posedge clk);
            if (expect_q.size() > 0) begin
                @(negedge clk);
                e = expect_q.pop_front();
                check_value("accepted", 32'(accepted), 32'(e.accepted));
                compare_resp("resp_1", resp_1, e.resp_1);
                compare_resp("resp_2", resp_2, e.resp_2);
                check_count++;
            end
        end
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD + 50 * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("Testbench failed");
        $fatal(1);
    end

    initial begin
        rename_pkg::rename_req_t r1;
        rename_pkg::rename_req_t r2;
        rename_pkg::release_t l1;
        rename_pkg::release_t l2;
        reset = 1'b1;
        req_1 = '0;
        req_2 = '0;
        rel_1 = '0;
        rel_2 = '0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
        check_value("resp_1.valid", 32'(resp_1.valid), 32'h0);
        check_value("resp_2.valid", 32'(resp_2.valid), 32'h0);
        check_value("accepted", 32'(accepted), 32'h0);

        // Identity map, first tags 32 and 33
        drive_cycle(make_req(1'b1, 5, 1'b1, 1, 1'b1, 2), make_req(1'b1, 6, 1'b1, 3, 1'b1, 4), '0, '0);
        // RAW and WAW inside one group, then a later read of x7
        drive_cycle(make_req(1'b1, 7, 1'b1, 5, 1'b1, 6), make_req(1'b1, 7, 1'b1, 7, 1'b1, 7), '0, '0);
        drive_cycle(make_req(1'b0, 0, 1'b1, 7, 1'b0, 0), '0, '0, '0);
        // Unused sources and a slot that writes nothing
        drive_cycle(make_req(1'b0, 9, 1'b0, 3, 1'b1, 8), make_req(1'b1, 10, 1'b1, 9, 1'b0, 4), '0, '0);

        while (model_free.size() >= 2) begin
            drive_cycle(make_req(1'b1, 11, 1'b1, 11, 1'b0, 0),
                        make_req(1'b1, 12, 1'b1, 11, 1'b0, 0), '0, '0);
        end
        if (model_free.size() == 1) begin
            drive_cycle(make_req(1'b1, 13, 1'b1, 12, 1'b0, 0), '0, '0, '0);
        end
        // Empty list, same-cycle releases do not help
        drive_cycle(make_req(1'b1, 14, 1'b1, 13, 1'b0, 0), '0, take_release(), take_release());
        drive_cycle(make_req(1'b0, 0, 1'b1, 14, 1'b1, 13),
                    make_req(1'b1, 15, 1'b1, 14, 1'b0, 0), take_release(), '0);
        drive_cycle(make_req(1'b1, 16, 1'b1, 15, 1'b0, 0),
                    make_req(1'b1, 17, 1'b1, 16, 1'b0, 0), '0, '0);

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            r1 = random_req();
            r2 = random_req();
            l1 = '0;
            l2 = '0;
            if (random_bit()) begin
                l1 = take_release();
            end
            if (random_bit()) begin
                l2 = take_release();
            end
            drive_cycle(r1, r2, l1, l2);
        end
        drive_cycle('0, '0, '0, '0);
        @(posedge clk);
        @(negedge clk);
        #1;

        if (expect_q.size() == 0 && check_count > 0 && reject_count > 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Run ended with %0d responses unchecked and %0d groups rejected",
                     expect_q.size(), reject_count);
            $display("Testbench failed");
            $fatal(1);
        end
    end

endmodule

//--- compile.f
+incdir+tests
common/rename_pkg.sv
rename/free_tag_list.sv
rename/map_table.sv
rename/group_bypass.sv
rename/rename_unit.sv
tests/rename_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module rename_tb -f compile.f -o rename_sim
	./obj_dir/rename_sim

clean:
	rm -rf obj_dir
